// File: Makefile
VERILATOR  ?= verilator
TOP        := dual_decode_tb
RTL_TOP    := dual_decode_stage
FILELIST   := all.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
SIM        := ./obj_dir/V$(TOP)

.PHONY: run build lint clean

run: build
	@out=$$($(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+include
hw/alpha_decode_pkg.sv
hw/inst_decoder.sv
hw/pair_issue.sv
hw/dual_decode_stage.sv
dv/dual_decode_tb.sv

// File: dv/dual_decode_tb.sv
// self-checking top-level testbench that drives random and directed pairs into the decode stage
`timescale 1ns/1ps
`default_nettype none

`include "alpha_isa_defs.svh"

module dual_decode_tb;

  import alpha_decode_pkg::*;

  localparam int period  = 4;
  localparam int n_rand  = 400;          // random pairs in the main run
  localparam int n_pairs = n_rand + 39;  // driven pairs plus two flush cycles
  localparam int n_tbl   = 45;

  // {opcode, function code} pairs where the function code only lands in operate words
  localparam logic [12:0] stim_tbl [n_tbl] = '{
    {OP_INTA, FN_ADDQ}, {OP_INTA, FN_SUBQ}, {OP_INTA, FN_CMPEQ}, {OP_INTA, FN_CMPULT},
    {OP_INTA, FN_CMPULE}, {OP_INTA, FN_CMPLT}, {OP_INTA, FN_CMPLE},
    {OP_INTL, FN_AND}, {OP_INTL, FN_BIC}, {OP_INTL, FN_BIS}, {OP_INTL, FN_ORNOT},
    {OP_INTL, FN_XOR}, {OP_INTL, FN_EQV},
    {OP_INTS, FN_SRL}, {OP_INTS, FN_SLL}, {OP_INTS, FN_SRA}, {OP_INTM, FN_MULQ},
    {OP_LDA, 7'h00}, {OP_LDQ, 7'h00}, {OP_STQ, 7'h00}, {OP_JSR, 7'h00},
    {OP_BR, 7'h00}, {OP_BSR, 7'h00},
    {OP_BLBC, 7'h00}, {OP_BEQ, 7'h00}, {OP_BLT, 7'h00}, {OP_BLE, 7'h00},
    {OP_BLBS, 7'h00}, {OP_BNE, 7'h00}, {OP_BGE, 7'h00}, {OP_BGT, 7'h00},
    // everything below decodes as illegal
    {OP_INTA, 7'h7f}, {OP_INTS, FN_ADDQ}, {OP_INTM, FN_SUBQ},
    {OP_FBEQ, 7'h00}, {OP_FBGT, 7'h00}, {OP_ITFP, 7'h00}, {OP_FLTV, 7'h00},
    {OP_FLTI, 7'h00}, {OP_FLTL, 7'h00}, {OP_MISC, 7'h00}, {OP_FTPI, 7'h00},
    {OP_PAL, 7'h00},                 // random pal field that is never the halt code
    {6'h09, 7'h00}, {6'h28, 7'h00}  // ldah and ldl
  };

  localparam logic [31:0] halt_word = {OP_PAL, `HALT_PAL_CODE};
  // addq r3 = r1 + r2
  localparam logic [31:0] addq_word = {OP_INTA, 5'd1, 5'd2, 3'b000, 1'b0, FN_ADDQ, 5'd3};
  // ldq r4 = 16(r5)
  localparam logic [31:0] ldq_word  = {OP_LDQ, 5'd4, 5'd5, 16'h0010};
  // stq r6 to 32(r7)
  localparam logic [31:0] stq_word  = {OP_STQ, 5'd6, 5'd7, 16'h0020};

  typedef struct packed {
    logic [1:0] opa;
    logic [1:0] opb;
    logic [4:0] alu;
    logic [4:0] dest;
    logic [4:0] srca;
    logic [4:0] srcb;
    logic       rd, wr, cb, ub, halt, illegal, valid;
  } lane_t;

  typedef struct packed {
    lane_t s1;
    lane_t s2;
    logic  dep_a, dep_b, halted;
  } pair_t;

  // dut side
  logic        clock = 1'b0;
  logic        rst_n;
  logic [31:0] inst_1, inst_2;
  logic        valid_1, valid_2;
  opa_sel_e    id_opa_select_1, id_opa_select_2;
  opb_sel_e    id_opb_select_1, id_opb_select_2;
  alu_func_e   id_alu_func_1, id_alu_func_2;
  logic [4:0]  id_dest_idx_1, id_src_a_idx_1, id_src_b_idx_1;
  logic [4:0]  id_dest_idx_2, id_src_a_idx_2, id_src_b_idx_2;
  logic        id_rd_mem_1, id_wr_mem_1, id_cond_branch_1, id_uncond_branch_1;
  logic        id_halt_1, id_illegal_1, id_valid_1;
  logic        id_rd_mem_2, id_wr_mem_2, id_cond_branch_2, id_uncond_branch_2;
  logic        id_halt_2, id_illegal_2, id_valid_2;
  logic        dep_a_2, dep_b_2, halted;

  // exp_in holds what the next rising edge should register
  pair_t       exp_in, exp_out;
  logic        in_armed;
  logic        out_armed = 1'b0;
  logic [31:0] lfsr;
  int          n_checks  = 0;
  int          n_errors  = 0;
  int          n_checked = 0;

  always #(period / 2) clock = ~clock;

  dual_decode_stage dut0 (.*);

  ////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // {known, alu op} for the operate groups
  function automatic logic [5:0] alu_ref(input logic [5:0] op, input logic [6:0] fn);
    case ({op, fn})
      {OP_INTA, FN_ADDQ}:   return {1'b1, ALU_ADDQ};
      {OP_INTA, FN_SUBQ}:   return {1'b1, ALU_SUBQ};
      {OP_INTA, FN_CMPEQ}:  return {1'b1, ALU_CMPEQ};
      {OP_INTA, FN_CMPULT}: return {1'b1, ALU_CMPULT};
      {OP_INTA, FN_CMPULE}: return {1'b1, ALU_CMPULE};
      {OP_INTA, FN_CMPLT}:  return {1'b1, ALU_CMPLT};
      {OP_INTA, FN_CMPLE}:  return {1'b1, ALU_CMPLE};
      {OP_INTL, FN_AND}:    return {1'b1, ALU_AND};
      {OP_INTL, FN_BIC}:    return {1'b1, ALU_BIC};
      {OP_INTL, FN_BIS}:    return {1'b1, ALU_BIS};
      {OP_INTL, FN_ORNOT}:  return {1'b1, ALU_ORNOT};
      {OP_INTL, FN_XOR}:    return {1'b1, ALU_XOR};
      {OP_INTL, FN_EQV}:    return {1'b1, ALU_EQV};
      {OP_INTS, FN_SRL}:    return {1'b1, ALU_SRL};
      {OP_INTS, FN_SLL}:    return {1'b1, ALU_SLL};
      {OP_INTS, FN_SRA}:    return {1'b1, ALU_SRA};
      {OP_INTM, FN_MULQ}:   return {1'b1, ALU_MULQ};
      default:              return 6'h00;  // unknown code keeps addq
    endcase
  endfunction

  // expected fields of one lane from the decode rules
  function automatic lane_t decode_ref(input logic [31:0] w, input logic vin);
    lane_t      r;
    logic [5:0] op;
    logic [5:0] alu_bits;
    logic       lit;
    r      = '0;  // selects 0, addq, flags low
    r.dest = `ZERO_REG;
    r.srca = `ZERO_REG;
    r.srcb = `ZERO_REG;
    op     = w[`ISA_OPCODE];
    lit    = w[`ISA_LIT];
    if (!vin)
      return r;
    if (op == OP_PAL)
    begin
      r.halt    = (w[`ISA_PAL_FUNC] == `HALT_PAL_CODE);
      r.illegal = !r.halt;
    end
    else if (op inside {OP_INTA, OP_INTL, OP_INTS, OP_INTM})
    begin
      alu_bits  = alu_ref(op, w[`ISA_FUNC]);
      r.alu     = alu_bits[4:0];
      r.illegal = !alu_bits[5];
      r.opb     = lit ? OPB_ALU_IMM : OPB_REGB;
      r.dest    = w[`ISA_RC];
      r.srca    = w[`ISA_RA];
      r.srcb    = lit ? `ZERO_REG : w[`ISA_RB];  // literal means no rb read
    end
    else if (op inside {OP_LDA, OP_LDQ, OP_STQ})
    begin
      r.opa  = OPA_MEM_DISP;  // disp + rb
      r.srcb = w[`ISA_RB];
      r.rd   = (op == OP_LDQ);
      r.wr   = (op == OP_STQ);
      if (r.wr)
        r.srca = w[`ISA_RA];  // store data
      else
        r.dest = w[`ISA_RA];
    end
    else if (op == OP_JSR)
    begin
      r.opa  = OPA_NOT3;
      r.alu  = ALU_AND;
      r.dest = w[`ISA_RA];
      r.srcb = w[`ISA_RB];
      r.ub   = 1'b1;
    end
    else if (op inside {OP_BR, OP_BSR})
    begin
      r.opa  = OPA_NPC;
      r.opb  = OPB_BR_DISP;
      r.dest = w[`ISA_RA];  // link
      r.ub   = 1'b1;
    end
    else if (op inside {OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT})
    begin
      r.opa  = OPA_NPC;
      r.opb  = OPB_BR_DISP;
      r.srca = w[`ISA_RA];
      r.cb   = 1'b1;
    end
    else
      r.illegal = 1'b1;  // fp branches, fp and misc groups, anything else
    r.valid = !r.illegal;
    return r;
  endfunction

  // all_flags also drops branches and illegal while the payload stays
  function automatic lane_t drop_flags(input lane_t l, input logic all_flags);
    l.valid = 1'b0;
    l.halt  = 1'b0;
    l.rd    = 1'b0;
    l.wr    = 1'b0;
    if (all_flags)
    begin
      l.cb      = 1'b0;
      l.ub      = 1'b0;
      l.illegal = 1'b0;
    end
    return l;
  endfunction

  function automatic pair_t pair_ref(input lane_t l1, input lane_t l2, input logic rst_val,
                                     input pair_t prev);
    pair_t p;
    logic  cut;
    p.s1 = l1;
    p.s2 = l2;
    cut  = (l1.valid && (l1.cb || l1.ub)) || l1.halt || l1.illegal;  // group ends at slot 1
    if (cut)
      p.s2 = drop_flags(p.s2, 1'b1);
    p.dep_a  = (l2.srca == l1.dest) && (l1.dest != `ZERO_REG);
    p.dep_b  = (l2.srcb == l1.dest) && (l1.dest != `ZERO_REG);
    p.halted = prev.halted || prev.s1.halt || prev.s2.halt;  // halt seen on last output
    if (p.halted)
    begin
      p.s1 = drop_flags(p.s1, 1'b0);
      p.s2 = drop_flags(p.s2, 1'b0);
    end
    if (!rst_val)
    begin
      p.s1     = drop_flags(p.s1, 1'b1);
      p.s2     = drop_flags(p.s2, 1'b1);
      p.dep_a  = 1'b0;
      p.dep_b  = 1'b0;
      p.halted = 1'b0;
    end
    return p;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_pair(input logic rst_val, input logic [31:0] w1, input logic v1,
                            input logic [31:0] w2, input logic v2);
    @(negedge clock);
    rst_n    = rst_val;
    inst_1   = w1;
    valid_1  = v1;
    inst_2   = w2;
    valid_2  = v2;
    exp_in   = pair_ref(decode_ref(w1, v1), decode_ref(w2, v2), rst_val, exp_in);
    in_armed = 1'b1;
  endtask

  task automatic rand_inst(output logic [31:0] w);
    logic [31:0] b;
    int          idx;
    take_bits(6, b);
    idx = int'(b[5:0]) % n_tbl;
    take_bits(26, b);
    w = {stim_tbl[idx][12:7], b[25:0]};  // random regs, literal and displacement
    if (stim_tbl[idx][12:7] inside {OP_INTA, OP_INTL, OP_INTS, OP_INTM})
      w[`ISA_FUNC] = stim_tbl[idx][6:0];
  endtask

  task automatic rand_pair();
    logic [31:0] w1, w2, b;
    logic        v1, v2;
    rand_inst(w1);
    rand_inst(w2);
    take_bits(3, b);
    if (b[2:0] == 3'd0)
    begin
      w1[`ISA_RA] = `ZERO_REG;  // r31 dest must never flag a dependency
      w1[`ISA_RC] = `ZERO_REG;
    end
    take_bits(2, b);
    if (!b[0])
      w2[`ISA_RA] = w1[`ISA_RC];  // slot 2 ra against operate dest
    if (!b[1])
      w2[`ISA_RB] = w1[`ISA_RA];  // slot 2 rb against load or link dest
    take_bits(4, b);
    v1 = |b[1:0];
    v2 = |b[3:2];
    drive_pair(1'b1, w1, v1, w2, v2);
  endtask

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    n_checks++;
    assert (act_v === exp_v)
    else
    begin
      $display("Fail t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      n_errors++;
    end
  endtask

  always @(posedge clock)
  begin
    exp_out   <= exp_in;  // one deep to line up with the dut register
    out_armed <= in_armed;
  end

  // outputs are settled half a cycle after the rising edge
  always @(negedge clock)
  begin
    if (out_armed)
    begin
      check_val("id_opa_select_1", 32'(exp_out.s1.opa), 32'(id_opa_select_1));
      check_val("id_opb_select_1", 32'(exp_out.s1.opb), 32'(id_opb_select_1));
      check_val("id_alu_func_1", 32'(exp_out.s1.alu), 32'(id_alu_func_1));
      check_val("id_dest_idx_1", 32'(exp_out.s1.dest), 32'(id_dest_idx_1));
      check_val("id_src_a_idx_1", 32'(exp_out.s1.srca), 32'(id_src_a_idx_1));
      check_val("id_src_b_idx_1", 32'(exp_out.s1.srcb), 32'(id_src_b_idx_1));
      check_val("id_rd_mem_1", 32'(exp_out.s1.rd), 32'(id_rd_mem_1));
      check_val("id_wr_mem_1", 32'(exp_out.s1.wr), 32'(id_wr_mem_1));
      check_val("id_cond_branch_1", 32'(exp_out.s1.cb), 32'(id_cond_branch_1));
      check_val("id_uncond_branch_1", 32'(exp_out.s1.ub), 32'(id_uncond_branch_1));
      check_val("id_halt_1", 32'(exp_out.s1.halt), 32'(id_halt_1));
      check_val("id_illegal_1", 32'(exp_out.s1.illegal), 32'(id_illegal_1));
      check_val("id_valid_1", 32'(exp_out.s1.valid), 32'(id_valid_1));
      check_val("id_opa_select_2", 32'(exp_out.s2.opa), 32'(id_opa_select_2));
      check_val("id_opb_select_2", 32'(exp_out.s2.opb), 32'(id_opb_select_2));
      check_val("id_alu_func_2", 32'(exp_out.s2.alu), 32'(id_alu_func_2));
      check_val("id_dest_idx_2", 32'(exp_out.s2.dest), 32'(id_dest_idx_2));
      check_val("id_src_a_idx_2", 32'(exp_out.s2.srca), 32'(id_src_a_idx_2));
      check_val("id_src_b_idx_2", 32'(exp_out.s2.srcb), 32'(id_src_b_idx_2));
      check_val("id_rd_mem_2", 32'(exp_out.s2.rd), 32'(id_rd_mem_2));
      check_val("id_wr_mem_2", 32'(exp_out.s2.wr), 32'(id_wr_mem_2));
      check_val("id_cond_branch_2", 32'(exp_out.s2.cb), 32'(id_cond_branch_2));
      check_val("id_uncond_branch_2", 32'(exp_out.s2.ub), 32'(id_uncond_branch_2));
      check_val("id_halt_2", 32'(exp_out.s2.halt), 32'(id_halt_2));
      check_val("id_illegal_2", 32'(exp_out.s2.illegal), 32'(id_illegal_2));
      check_val("id_valid_2", 32'(exp_out.s2.valid), 32'(id_valid_2));
      check_val("dep_a_2", 32'(exp_out.dep_a), 32'(dep_a_2));
      check_val("dep_b_2", 32'(exp_out.dep_b), 32'(dep_b_2));
      check_val("halted", 32'(exp_out.halted), 32'(halted));
      n_checked++;
    end
  end

  ////////////////////////////////////////////////////////////
  // run
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n    = 1'b0;  // low over the first three rising edges
    inst_1   = '0;
    valid_1  = 1'b0;
    inst_2   = '0;
    valid_2  = 1'b0;
    lfsr     = 32'h80e;
    exp_in   = '0;
    in_armed = 1'b0;
    repeat (2) drive_pair(1'b0, '0, 1'b0, '0, 1'b0);
    repeat (n_rand) rand_pair();
    // halt in slot 2 silences everything after it
    drive_pair(1'b1, addq_word, 1'b1, halt_word, 1'b1);
    // loads, stores and halts in either slot stay quiet
    drive_pair(1'b1, ldq_word, 1'b1, halt_word, 1'b1);
    drive_pair(1'b1, stq_word, 1'b1, ldq_word, 1'b1);
    drive_pair(1'b1, halt_word, 1'b1, stq_word, 1'b1);
    drive_pair(1'b1, addq_word, 1'b1, stq_word, 1'b1);
    repeat (2) rand_pair();
    // reset with busy inputs clears halted
    repeat (3) drive_pair(1'b0, addq_word, 1'b1, addq_word, 1'b1);
    repeat (20) rand_pair();
    drive_pair(1'b1, halt_word, 1'b1, addq_word, 1'b1);  // halt in slot 1 cuts slot 2
    repeat (4) rand_pair();
    repeat (2) @(negedge clock);  // let the last pair reach the compare
    #1;
    $display("summary: %0d pairs checked, %0d checks, %0d errors",
             n_checked, n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    #((n_pairs + 20) * period);
    $display("watchdog expired, stimulus did not finish within %0d cycles", n_pairs + 20);
    $display("summary: %0d pairs checked, %0d checks, %0d errors",
             n_checked, n_checks, n_errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/alpha_decode_pkg.sv
// opcode, function code, alu and operand select enums for the decode stage; import in body
`default_nettype none

package alpha_decode_pkg;

  // primary opcodes, inst[31:26]
  typedef enum logic [5:0] {
    // pal, memory and integer operate groups
    OP_PAL  = 6'h00, OP_LDA  = 6'h08, OP_LDQ  = 6'h29, OP_STQ  = 6'h2d,
    OP_INTA = 6'h10, OP_INTL = 6'h11, OP_INTS = 6'h12, OP_INTM = 6'h13,
    // fp operate and misc groups, all unimplemented
    OP_ITFP = 6'h14, OP_FLTV = 6'h15, OP_FLTI = 6'h16, OP_FLTL = 6'h17,
    OP_MISC = 6'h18, OP_JSR  = 6'h1a, OP_FTPI = 6'h1c,
    // unconditional branches
    OP_BR   = 6'h30, OP_BSR  = 6'h34,
    // fp conditional branches
    OP_FBEQ = 6'h31, OP_FBLT = 6'h32, OP_FBLE = 6'h33,
    OP_FBNE = 6'h35, OP_FBGE = 6'h36, OP_FBGT = 6'h37,
    // integer conditional branches
    OP_BLBC = 6'h38, OP_BEQ  = 6'h39, OP_BLT  = 6'h3a, OP_BLE  = 6'h3b,
    OP_BLBS = 6'h3c, OP_BNE  = 6'h3d, OP_BGE  = 6'h3e, OP_BGT  = 6'h3f
  } opcode_e;

  // operate function codes, inst[11:5]
  // codes repeat across groups, the enum holds each value once
  typedef enum logic [6:0] {
    FN_ADDQ   = 7'h20,  // inta
    FN_SUBQ   = 7'h29,
    FN_CMPEQ  = 7'h2d,
    FN_CMPULT = 7'h1d,
    FN_CMPULE = 7'h3d,
    FN_CMPLT  = 7'h4d,
    FN_CMPLE  = 7'h6d,
    FN_AND    = 7'h00,  // intl
    FN_BIC    = 7'h08,
    FN_ORNOT  = 7'h28,
    FN_XOR    = 7'h40,
    FN_EQV    = 7'h48,
    FN_SRL    = 7'h34,  // ints
    FN_SLL    = 7'h39,
    FN_SRA    = 7'h3c
  } func_e;

  localparam func_e FN_BIS  = FN_ADDQ;  // intl 0x20
  localparam func_e FN_MULQ = FN_ADDQ;  // intm 0x20

  // alu operation, addq at zero so a noop adds
  typedef enum logic [4:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_CMPEQ,
    ALU_CMPULT,
    ALU_CMPULE,
    ALU_CMPLT,
    ALU_CMPLE,
    ALU_AND,
    ALU_BIC,
    ALU_BIS,
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_MULQ
  } alu_func_e;

  // alu operand a source
  typedef enum logic [1:0] {
    OPA_REGA,      // register ra
    OPA_MEM_DISP,  // sign extended memory displacement
    OPA_NPC,       // next pc, for branch targets
    OPA_NOT3       // ~64'h3, jump word align mask
  } opa_sel_e;

  // alu operand b source
  typedef enum logic [1:0] {
    OPB_REGB,     // register rb
    OPB_ALU_IMM,  // 8 bit operate literal
    OPB_BR_DISP   // branch displacement
  } opb_sel_e;

endpackage

`default_nettype wire

// File: hw/dual_decode_stage.sv
// two wide decode stage top, two lane decoders feeding the pair combiner
`timescale 1ns/1ps
`default_nettype none

module dual_decode_stage (
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic [31:0]                inst_1,
  input  logic                       valid_1,
  input  logic [31:0]                inst_2,
  input  logic                       valid_2,
  // dispatch slot 1
  output alpha_decode_pkg::opa_sel_e  id_opa_select_1,
  output alpha_decode_pkg::opb_sel_e  id_opb_select_1,
  output alpha_decode_pkg::alu_func_e id_alu_func_1,
  output logic [4:0]                 id_dest_idx_1, id_src_a_idx_1, id_src_b_idx_1,
  output logic                       id_rd_mem_1, id_wr_mem_1,
  output logic                       id_cond_branch_1, id_uncond_branch_1,
  output logic                       id_halt_1, id_illegal_1, id_valid_1,
  // dispatch slot 2
  output alpha_decode_pkg::opa_sel_e  id_opa_select_2,
  output alpha_decode_pkg::opb_sel_e  id_opb_select_2,
  output alpha_decode_pkg::alu_func_e id_alu_func_2,
  output logic [4:0]                 id_dest_idx_2, id_src_a_idx_2, id_src_b_idx_2,
  output logic                       id_rd_mem_2, id_wr_mem_2,
  output logic                       id_cond_branch_2, id_uncond_branch_2,
  output logic                       id_halt_2, id_illegal_2, id_valid_2,
  output logic                       dep_a_2,
  output logic                       dep_b_2,
  output logic                       halted
);

  import alpha_decode_pkg::*;

  // lane 1 decode
  opa_sel_e   opa_select_1;
  opb_sel_e   opb_select_1;
  alu_func_e  alu_func_1;
  logic [4:0] dest_idx_1, src_a_idx_1, src_b_idx_1;
  logic       rd_mem_1, wr_mem_1, cond_branch_1, uncond_branch_1;
  logic       halt_1, illegal_1;
  logic       lane_valid_1;  // valid_1 is taken by the fetch input

  // lane 2 decode
  opa_sel_e   opa_select_2;
  opb_sel_e   opb_select_2;
  alu_func_e  alu_func_2;
  logic [4:0] dest_idx_2, src_a_idx_2, src_b_idx_2;
  logic       rd_mem_2, wr_mem_2, cond_branch_2, uncond_branch_2;
  logic       halt_2, illegal_2;
  logic       lane_valid_2;

  inst_decoder decoder_1 (
    .inst        (inst_1),
    .valid_in    (valid_1),
    .opa_select  (opa_select_1),
    .opb_select  (opb_select_1),
    .alu_func    (alu_func_1),
    .dest_idx    (dest_idx_1),
    .src_a_idx   (src_a_idx_1),
    .src_b_idx   (src_b_idx_1),
    .rd_mem      (rd_mem_1),
    .wr_mem      (wr_mem_1),
    .cond_branch (cond_branch_1),
    .uncond_branch(uncond_branch_1),
    .halt        (halt_1),
    .illegal     (illegal_1),
    .valid       (lane_valid_1)
  );

  inst_decoder decoder_2 (
    .inst        (inst_2),
    .valid_in    (valid_2),
    .opa_select  (opa_select_2),
    .opb_select  (opb_select_2),
    .alu_func    (alu_func_2),
    .dest_idx    (dest_idx_2),
    .src_a_idx   (src_a_idx_2),
    .src_b_idx   (src_b_idx_2),
    .rd_mem      (rd_mem_2),
    .wr_mem      (wr_mem_2),
    .cond_branch (cond_branch_2),
    .uncond_branch(uncond_branch_2),
    .halt        (halt_2),
    .illegal     (illegal_2),
    .valid       (lane_valid_2)
  );

  // remaining ports match by name
  pair_issue issue0 (
    .valid_1(lane_valid_1),
    .valid_2(lane_valid_2),
    .*
  );

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
// combinational decoder for one instruction word, one instance per decode lane
`timescale 1ns/1ps
`default_nettype none

`include "alpha_isa_defs.svh"

module inst_decoder (
  input  logic [31:0]                inst,
  input  logic                       valid_in,  // low gives noop defaults
  output alpha_decode_pkg::opa_sel_e  opa_select,
  output alpha_decode_pkg::opb_sel_e  opb_select,
  output alpha_decode_pkg::alu_func_e alu_func,
  output logic [4:0]                 dest_idx,   // ZERO_REG when nothing written
  output logic [4:0]                 src_a_idx,  // ZERO_REG when ra not read
  output logic [4:0]                 src_b_idx,  // ZERO_REG when rb not read
  output logic                       rd_mem,
  output logic                       wr_mem,
  output logic                       cond_branch,
  output logic                       uncond_branch,
  output logic                       halt,
  output logic                       illegal,
  output logic                       valid  // counts toward retired insts
);

  import alpha_decode_pkg::*;

  // which field feeds the writeback index
  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_RA,
    DEST_RC
  } dest_sel_e;

  opcode_e   opcode;
  func_e     func;
  dest_sel_e dest_sel;
  logic      use_ra;  // ra is read as a source
  logic      use_rb;  // rb is read as a source

  assign opcode = opcode_e'(inst[`ISA_OPCODE]);
  assign func   = func_e'(inst[`ISA_FUNC]);

  ////////////////////////////////////////////////////////////
  // control pla
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // noop defaults, each group overrides what it needs
    opa_select    = OPA_REGA;
    opb_select    = OPB_REGB;
    alu_func      = ALU_ADDQ;
    dest_sel      = DEST_NONE;
    use_ra        = 1'b0;
    use_rb        = 1'b0;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    if (valid_in)
    begin
      case (opcode)
        OP_PAL:
          if (inst[`ISA_PAL_FUNC] == `HALT_PAL_CODE)
            halt = 1'b1;
          else
            illegal = 1'b1;  // only halt supported
        OP_INTA, OP_INTL, OP_INTS, OP_INTM:
        begin
          opa_select = OPA_REGA;
          opb_select = inst[`ISA_LIT] ? OPB_ALU_IMM : OPB_REGB;
          dest_sel   = DEST_RC;
          use_ra     = 1'b1;
          use_rb     = !inst[`ISA_LIT];  // literal replaces rb
          case (opcode)
            OP_INTA:
              case (func)
                FN_ADDQ:   alu_func = ALU_ADDQ;
                FN_SUBQ:   alu_func = ALU_SUBQ;
                FN_CMPEQ:  alu_func = ALU_CMPEQ;
                FN_CMPULT: alu_func = ALU_CMPULT;
                FN_CMPULE: alu_func = ALU_CMPULE;
                FN_CMPLT:  alu_func = ALU_CMPLT;
                FN_CMPLE:  alu_func = ALU_CMPLE;
                default:   illegal  = 1'b1;
              endcase
            OP_INTL:
              case (func)
                FN_AND:   alu_func = ALU_AND;
                FN_BIC:   alu_func = ALU_BIC;
                FN_BIS:   alu_func = ALU_BIS;
                FN_ORNOT: alu_func = ALU_ORNOT;
                FN_XOR:   alu_func = ALU_XOR;
                FN_EQV:   alu_func = ALU_EQV;
                default:  illegal  = 1'b1;
              endcase
            OP_INTS:
              case (func)
                FN_SRL:  alu_func = ALU_SRL;
                FN_SLL:  alu_func = ALU_SLL;
                FN_SRA:  alu_func = ALU_SRA;
                default: illegal  = 1'b1;
              endcase
            default:  // intm, mulq only
              if (func == FN_MULQ)
                alu_func = ALU_MULQ;
              else
                illegal = 1'b1;
          endcase
        end
        OP_JSR:
        begin
          // jmp, jsr, ret and jsr_co behave the same
          opa_select    = OPA_NOT3;
          opb_select    = OPB_REGB;
          alu_func      = ALU_AND;  // rb & ~3 word aligns the target
          dest_sel      = DEST_RA;  // return address
          use_rb        = 1'b1;
          uncond_branch = 1'b1;
        end
        OP_LDA, OP_LDQ, OP_STQ:
        begin
          // effective address is rb + disp
          opa_select = OPA_MEM_DISP;
          opb_select = OPB_REGB;
          alu_func   = ALU_ADDQ;
          use_rb     = 1'b1;  // lda reads its base too
          rd_mem     = (opcode == OP_LDQ);
          wr_mem     = (opcode == OP_STQ);
          use_ra     = (opcode == OP_STQ);  // store data
          dest_sel   = (opcode == OP_STQ) ? DEST_NONE : DEST_RA;
        end
        OP_BR, OP_BSR,
        OP_BLBC, OP_BEQ, OP_BLT, OP_BLE, OP_BLBS, OP_BNE, OP_BGE, OP_BGT:
        begin
          opa_select = OPA_NPC;  // target = npc + disp
          opb_select = OPB_BR_DISP;
          alu_func   = ALU_ADDQ;
          if (opcode == OP_BR || opcode == OP_BSR)
          begin
            dest_sel      = DEST_RA;  // link register
            uncond_branch = 1'b1;
          end
          else
          begin
            use_ra      = 1'b1;  // tested register
            cond_branch = 1'b1;
          end
        end
        OP_FBEQ, OP_FBLT, OP_FBLE, OP_FBNE, OP_FBGE, OP_FBGT:
          illegal = 1'b1;  // no fp branches
        OP_ITFP, OP_FLTV, OP_FLTI, OP_FLTL, OP_MISC, OP_FTPI:
          illegal = 1'b1;  // unimplemented groups
        default:
          illegal = 1'b1;  // lda variants, other loads and stores
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // register index muxes
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (dest_sel)
      DEST_RA: dest_idx = inst[`ISA_RA];
      DEST_RC: dest_idx = inst[`ISA_RC];
      default: dest_idx = `ZERO_REG;
    endcase
  end

  assign src_a_idx = use_ra ? inst[`ISA_RA] : `ZERO_REG;
  assign src_b_idx = use_rb ? inst[`ISA_RB] : `ZERO_REG;

  assign valid = valid_in & ~illegal;  // halt stays valid

endmodule

`default_nettype wire

// File: hw/pair_issue.sv
// combines both decode lanes into the registered dispatch pair, with group cut and halt
`timescale 1ns/1ps
`default_nettype none

`include "alpha_isa_defs.svh"

module pair_issue (
  input  logic                       clock,
  input  logic                       rst_n,
  // lane 1 from decoder_1
  input  alpha_decode_pkg::opa_sel_e  opa_select_1,
  input  alpha_decode_pkg::opb_sel_e  opb_select_1,
  input  alpha_decode_pkg::alu_func_e alu_func_1,
  input  logic [4:0]                 dest_idx_1, src_a_idx_1, src_b_idx_1,
  input  logic                       rd_mem_1, wr_mem_1, cond_branch_1, uncond_branch_1,
  input  logic                       halt_1, illegal_1, valid_1,
  // lane 2 from decoder_2
  input  alpha_decode_pkg::opa_sel_e  opa_select_2,
  input  alpha_decode_pkg::opb_sel_e  opb_select_2,
  input  alpha_decode_pkg::alu_func_e alu_func_2,
  input  logic [4:0]                 dest_idx_2, src_a_idx_2, src_b_idx_2,
  input  logic                       rd_mem_2, wr_mem_2, cond_branch_2, uncond_branch_2,
  input  logic                       halt_2, illegal_2, valid_2,
  // dispatch slot 1
  output alpha_decode_pkg::opa_sel_e  id_opa_select_1,
  output alpha_decode_pkg::opb_sel_e  id_opb_select_1,
  output alpha_decode_pkg::alu_func_e id_alu_func_1,
  output logic [4:0]                 id_dest_idx_1, id_src_a_idx_1, id_src_b_idx_1,
  output logic                       id_rd_mem_1, id_wr_mem_1,
  output logic                       id_cond_branch_1, id_uncond_branch_1,
  output logic                       id_halt_1, id_illegal_1, id_valid_1,
  // dispatch slot 2
  output alpha_decode_pkg::opa_sel_e  id_opa_select_2,
  output alpha_decode_pkg::opb_sel_e  id_opb_select_2,
  output alpha_decode_pkg::alu_func_e id_alu_func_2,
  output logic [4:0]                 id_dest_idx_2, id_src_a_idx_2, id_src_b_idx_2,
  output logic                       id_rd_mem_2, id_wr_mem_2,
  output logic                       id_cond_branch_2, id_uncond_branch_2,
  output logic                       id_halt_2, id_illegal_2, id_valid_2,
  output logic                       dep_a_2,  // slot 2 ra reads slot 1 dest
  output logic                       dep_b_2,  // slot 2 rb reads slot 1 dest
  output logic                       halted    // sticky until reset
);

  import alpha_decode_pkg::*;

  logic                  cut_2;       // slot 1 ends the fetch group
  logic                  keep_2;
  logic [`NUM_LANES-1:0] halt_seen;  // halt leaving this cycle, per slot
  logic                  silence;    // masks everything from here on

  // redirect, halt or trap in slot 1 drops slot 2
  assign cut_2  = (valid_1 & (cond_branch_1 | uncond_branch_1)) | halt_1 | illegal_1;
  assign keep_2 = ~cut_2;

  assign halt_seen = {id_halt_2, id_halt_1};
  assign silence   = halted | (|halt_seen);

  ////////////////////////////////////////////////////////////
  // payload fields
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    id_opa_select_1 <= opa_select_1;
    id_opb_select_1 <= opb_select_1;
    id_alu_func_1   <= alu_func_1;
    id_dest_idx_1   <= dest_idx_1;
    id_src_a_idx_1  <= src_a_idx_1;
    id_src_b_idx_1  <= src_b_idx_1;
    id_opa_select_2 <= opa_select_2;  // kept even when cut
    id_opb_select_2 <= opb_select_2;
    id_alu_func_2   <= alu_func_2;
    id_dest_idx_2   <= dest_idx_2;
    id_src_a_idx_2  <= src_a_idx_2;
    id_src_b_idx_2  <= src_b_idx_2;
  end

  ////////////////////////////////////////////////////////////
  // control flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      id_rd_mem_1        <= 1'b0;
      id_wr_mem_1        <= 1'b0;
      id_cond_branch_1   <= 1'b0;
      id_uncond_branch_1 <= 1'b0;
      id_halt_1          <= 1'b0;
      id_illegal_1       <= 1'b0;
      id_valid_1         <= 1'b0;
      id_rd_mem_2        <= 1'b0;
      id_wr_mem_2        <= 1'b0;
      id_cond_branch_2   <= 1'b0;
      id_uncond_branch_2 <= 1'b0;
      id_halt_2          <= 1'b0;
      id_illegal_2       <= 1'b0;
      id_valid_2         <= 1'b0;
      dep_a_2            <= 1'b0;
      dep_b_2            <= 1'b0;
      halted             <= 1'b0;
    end
    else
    begin
      id_rd_mem_1        <= rd_mem_1 & ~silence;
      id_wr_mem_1        <= wr_mem_1 & ~silence;
      id_cond_branch_1   <= cond_branch_1;
      id_uncond_branch_1 <= uncond_branch_1;
      id_halt_1          <= halt_1 & ~silence;
      id_illegal_1       <= illegal_1;
      id_valid_1         <= valid_1 & ~silence;
      // slot 2 flags only survive if the group continues
      id_rd_mem_2        <= rd_mem_2 & keep_2 & ~silence;
      id_wr_mem_2        <= wr_mem_2 & keep_2 & ~silence;
      id_cond_branch_2   <= cond_branch_2 & keep_2;
      id_uncond_branch_2 <= uncond_branch_2 & keep_2;
      id_halt_2          <= halt_2 & keep_2 & ~silence;
      id_illegal_2       <= illegal_2 & keep_2;
      id_valid_2         <= valid_2 & keep_2 & ~silence;
      // r31 writes nothing, so it never creates a dependency
      dep_a_2 <= (src_a_idx_2 == dest_idx_1) && (dest_idx_1 != `ZERO_REG);
      dep_b_2 <= (src_b_idx_2 == dest_idx_1) && (dest_idx_1 != `ZERO_REG);
      halted  <= halted | (|halt_seen);  // one cycle after halt leaves
    end
  end

endmodule

`default_nettype wire

// File: include/alpha_isa_defs.svh
// alpha instruction field positions and decode constants, included by the decode rtl
`ifndef ALPHA_ISA_DEFS_SVH
`define ALPHA_ISA_DEFS_SVH

////////////////////////////////////////////////////////////
// instruction word fields
////////////////////////////////////////////////////////////

`define ISA_OPCODE    31:26  // primary opcode
`define ISA_RA        25:21  // ra, dest of loads / jumps
`define ISA_RB        20:16  // rb, base or second operand
`define ISA_LIT       12     // operate literal flag
`define ISA_FUNC      11:5   // operate function code
`define ISA_RC        4:0    // rc, operate dest
`define ISA_PAL_FUNC  25:0   // call_pal function field

////////////////////////////////////////////////////////////
// constants
////////////////////////////////////////////////////////////

// r31 reads as zero, so it doubles as "no register"
`define ZERO_REG      5'd31

`define HALT_PAL_CODE 26'h0000555  // call_pal halt

`define NUM_LANES     2  // decode width

`endif
